//--- hw/line_mem_pkg.sv
package line_mem_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int ADDR_W      = 64;
    localparam int ID_W        = 16;
    localparam int OFFSET_W    = 6;        // 64-byte line
    localparam int DATA_W      = 512;
    localparam int TAG_S       = 64;       // stored tag entry
    localparam int TAG_FIELD_W = 32;       // upper address bits kept

    // ----------------------------------------
    // field positions
    // ----------------------------------------
    // address bits copied into addr_tag
    localparam int TAG_ADDR_HI = ADDR_W - 1;
    localparam int TAG_ADDR_LO = ADDR_W - TAG_FIELD_W;

    // valid + dirty + addr_tag, rest is padding
    localparam int PAD_W = TAG_S - 2 - TAG_FIELD_W;

    // ----------------------------------------
    // payload types
    // ----------------------------------------
    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [TAG_FIELD_W-1:0] addr_tag;
        logic [PAD_W-1:0]       pad;   // always zero
    } tag_entry_t;

    typedef logic [DATA_W-1:0] line_data_t;

    // ----------------------------------------
    // channel payloads
    // ----------------------------------------
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
    } ar_req_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
    } aw_req_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        line_data_t      data;
    } w_beat_t;

    // tag entry sits above the data, as on the R bus
    typedef struct packed {
        logic [ID_W-1:0] id;
        tag_entry_t      tag;
        line_data_t      data;
    } r_beat_t;

endpackage

//--- hw/line_store.sv
`timescale 1ns/10ps

module line_store #(
    parameter int  INDEX_W   = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic               clk,

    // write port
    input  logic               we_i,
    input  logic [INDEX_W-1:0] waddr_i,
    input  payload_t           wdata_i,

    // read port, combinational
    input  logic [INDEX_W-1:0] raddr_i,
    output payload_t           rdata_o
);

    localparam int DEPTH = 2 ** INDEX_W;

    // no reset, content of an unwritten entry is undefined
    payload_t mem [DEPTH];

    // ----------------------------------------
    // write side
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // ----------------------------------------
    // read side
    // ----------------------------------------
    // a line written at an edge is visible right after it
    assign rdata_o = mem[raddr_i];

    // an X index would smear the write over the array
    a_known_waddr : assert property (
        @(posedge clk) we_i |-> !$isunknown(waddr_i)
    ) else $error("line_store: unknown write index with we_i high");

endmodule

//--- hw/line_write_ctrl.sv
`timescale 1ns/10ps

module line_write_ctrl #(
    parameter int INDEX_W = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // AW channel
    input  line_mem_pkg::aw_req_t        aw_i,
    input  logic                         awvalid_i,
    output logic                         awready_o,

    // W channel
    input  line_mem_pkg::w_beat_t        w_i,
    input  logic                         wvalid_i,
    output logic                         wready_o,

    // B channel
    output logic [line_mem_pkg::ID_W-1:0] bid_o,
    output logic                         bvalid_o,
    input  logic                         bready_i,

    // store write port
    output logic                         we_o,
    output logic [INDEX_W-1:0]           windex_o,
    output line_mem_pkg::tag_entry_t     wtag_o,
    output line_mem_pkg::line_data_t     wline_o
);

    typedef enum logic [1:0] {
        W_IDLE    = 2'd0,
        W_CAPTURE = 2'd1,
        W_RUN     = 2'd2,
        W_RESP    = 2'd3
    } wstate_e;

    wstate_e                       state_q, state_d;
    logic [INDEX_W-1:0]            windex_q;
    line_mem_pkg::tag_entry_t      wtag_q;
    logic [line_mem_pkg::ID_W-1:0] wid_q;

    // ----------------------------------------
    // state register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= W_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            W_IDLE:    if (awvalid_i) state_d = W_CAPTURE;
            W_CAPTURE: state_d = W_RUN;   // one cycle only
            W_RUN:     if (wvalid_i) state_d = W_RESP;
            W_RESP:    if (bready_i) state_d = W_IDLE;
            default:   state_d = W_IDLE;
        endcase
    end

    // ----------------------------------------
    // capture of index, tag entry and id
    // ----------------------------------------
    // AW payload is held stable until awready_o
    always_ff @(posedge clk) begin
        if (state_q == W_CAPTURE) begin
            windex_q        <= aw_i.addr[line_mem_pkg::OFFSET_W +: INDEX_W];
            wtag_q.valid    <= 1'b1;
            wtag_q.dirty    <= 1'b0;   // fresh refill is clean
            wtag_q.addr_tag <= aw_i.addr[line_mem_pkg::TAG_ADDR_HI:line_mem_pkg::TAG_ADDR_LO];
            wtag_q.pad      <= '0;
            wid_q           <= aw_i.id;
        end
    end

    assign awready_o = (state_q == W_RUN);
    assign wready_o  = (state_q == W_RUN);

    // commit tag and data together on the W transfer
    assign we_o     = (state_q == W_RUN) && wvalid_i;
    assign windex_o = windex_q;
    assign wtag_o   = wtag_q;
    assign wline_o  = w_i.data;

    assign bvalid_o = (state_q == W_RESP);
    assign bid_o    = wid_q;

    // B must not drop or change before the master takes it
    a_b_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (bvalid_o && !bready_i) |=> (bvalid_o && $stable(bid_o))
    ) else $error("line_write_ctrl: B response changed before bready_i");

    // capture samples aw_i a cycle after it is first seen
    a_aw_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (awvalid_i && !awready_o) |=> (awvalid_i && $stable(aw_i))
    ) else $error("line_write_ctrl: AW request changed before awready_o");

endmodule

//--- hw/line_read_ctrl.sv
`timescale 1ns/10ps

module line_read_ctrl #(
    parameter int INDEX_W = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // AR channel
    input  line_mem_pkg::ar_req_t    ar_i,
    input  logic                     arvalid_i,
    output logic                     arready_o,

    // R channel
    output line_mem_pkg::r_beat_t    r_o,
    output logic                     rvalid_o,
    input  logic                     rready_i,

    // store read port
    output logic [INDEX_W-1:0]       rindex_o,
    input  line_mem_pkg::tag_entry_t rtag_i,
    input  line_mem_pkg::line_data_t rline_i
);

    typedef enum logic [1:0] {
        R_IDLE   = 2'd0,
        R_ACCEPT = 2'd1,
        R_RETURN = 2'd2
    } rstate_e;

    rstate_e               state_q, state_d;
    line_mem_pkg::r_beat_t r_q;

    // ----------------------------------------
    // state register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= R_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            R_IDLE:   if (arvalid_i) state_d = R_ACCEPT;
            R_ACCEPT: state_d = R_RETURN;   // AR transfer here
            R_RETURN: if (rready_i) state_d = R_IDLE;
            default:  state_d = R_IDLE;
        endcase
    end

    // index straight from the held AR address
    assign rindex_o  = ar_i.addr[line_mem_pkg::OFFSET_W +: INDEX_W];
    assign arready_o = (state_q == R_ACCEPT);

    // ----------------------------------------
    // R beat, latched at the end of accept
    // ----------------------------------------
    // a write landing on the same edge is not seen, old line returns
    always_ff @(posedge clk) begin
        if (state_q == R_ACCEPT) begin
            r_q.id   <= ar_i.id;
            r_q.tag  <= rtag_i;
            r_q.data <= rline_i;
        end
    end

    assign r_o      = r_q;
    assign rvalid_o = (state_q == R_RETURN);

    // payload frozen under back-pressure, even with writes going on
    a_r_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (rvalid_o && !rready_i) |=> (rvalid_o && $stable(r_o))
    ) else $error("line_read_ctrl: R beat changed before rready_i");

endmodule

//--- hw/line_mem.sv
`timescale 1ns/10ps

module line_mem #(
    parameter int INDEX_W = 4   // 2**INDEX_W lines
) (
    input  logic                          clk,
    input  logic                          rst_n,

    // AR / R
    input  line_mem_pkg::ar_req_t         ar_i,
    input  logic                          arvalid_i,
    output logic                          arready_o,
    output line_mem_pkg::r_beat_t         r_o,
    output logic                          rvalid_o,
    input  logic                          rready_i,

    // AW / W / B
    input  line_mem_pkg::aw_req_t         aw_i,
    input  logic                          awvalid_i,
    output logic                          awready_o,
    input  line_mem_pkg::w_beat_t         w_i,
    input  logic                          wvalid_i,
    output logic                          wready_o,
    output logic [line_mem_pkg::ID_W-1:0] bid_o,
    output logic                          bvalid_o,
    input  logic                          bready_i
);

    // ----------------------------------------
    // store ports
    // ----------------------------------------
    logic                     we;
    logic [INDEX_W-1:0]       windex;
    logic [INDEX_W-1:0]       rindex;
    line_mem_pkg::tag_entry_t wtag, rtag;
    line_mem_pkg::line_data_t wline, rline;

    line_write_ctrl #(
        .INDEX_W (INDEX_W)
    ) u_write_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw_i      (aw_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .w_i       (w_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bid_o     (bid_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .we_o      (we),
        .windex_o  (windex),
        .wtag_o    (wtag),
        .wline_o   (wline)
    );

    line_read_ctrl #(
        .INDEX_W (INDEX_W)
    ) u_read_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .ar_i      (ar_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .r_o       (r_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .rindex_o  (rindex),
        .rtag_i    (rtag),
        .rline_i   (rline)
    );

    // tag and data share write enable and indices
    line_store #(
        .INDEX_W   (INDEX_W),
        .payload_t (line_mem_pkg::tag_entry_t)
    ) u_tag_store (
        .clk     (clk),
        .we_i    (we),
        .waddr_i (windex),
        .wdata_i (wtag),
        .raddr_i (rindex),
        .rdata_o (rtag)
    );

    line_store #(
        .INDEX_W   (INDEX_W),
        .payload_t (line_mem_pkg::line_data_t)
    ) u_data_store (
        .clk     (clk),
        .we_i    (we),
        .waddr_i (windex),
        .wdata_i (wline),
        .raddr_i (rindex),
        .rdata_o (rline)
    );

endmodule

//--- tests/line_mem_tb.sv
`timescale 1ns/10ps

module line_mem_tb;

    localparam int INDEX_W    = 4;
    localparam int LINES      = 2 ** INDEX_W;
    localparam int WAIT_LIMIT = 40;   // cycles per handshake wait

    logic clk;
    logic rst_n;

    line_mem_pkg::ar_req_t         ar_i;
    logic                          arvalid_i, arready_o;
    line_mem_pkg::r_beat_t         r_o;
    logic                          rvalid_o, rready_i;
    line_mem_pkg::aw_req_t         aw_i;
    logic                          awvalid_i, awready_o;
    line_mem_pkg::w_beat_t         w_i;
    logic                          wvalid_i, wready_o;
    logic [line_mem_pkg::ID_W-1:0] bid_o;
    logic                          bvalid_o, bready_i;

    integer seed;
    int     errors, errors_at_start, tests_run, tests_failed;
    logic   quiet;   // window right after reset, no request yet

    // reference model, one entry per line index
    line_mem_pkg::tag_entry_t      model_tag [LINES];
    line_mem_pkg::line_data_t      model_data [LINES];
    logic                          model_written [LINES];
    line_mem_pkg::r_beat_t         exp_r;
    logic [line_mem_pkg::ID_W-1:0] exp_bid;
    logic [INDEX_W-1:0]            ar_index, w_index;

    line_mem #(
        .INDEX_W (INDEX_W)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .ar_i      (ar_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .r_o       (r_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .aw_i      (aw_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .w_i       (w_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bid_o     (bid_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // valid 1, dirty 0, upper 32 address bits, zero pad
    function automatic line_mem_pkg::tag_entry_t expected_tag(input logic [63:0] addr);
        line_mem_pkg::tag_entry_t t;
        t.valid    = 1'b1;
        t.dirty    = 1'b0;
        t.addr_tag = addr[63:32];
        t.pad      = '0;
        return t;
    endfunction

    // ----------------------------------------
    // model update on the transfer edges
    // ----------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < LINES; i++) begin
                model_written[i] <= 1'b0;
            end
        end else begin
            if (arvalid_i && arready_o) begin
                ar_index = ar_i.addr[line_mem_pkg::OFFSET_W +: INDEX_W];
                exp_r.id   <= ar_i.id;
                exp_r.tag  <= model_tag[ar_index];   // old line if written on this edge
                exp_r.data <= model_data[ar_index];
            end
            if (wvalid_i && wready_o) begin
                w_index = aw_i.addr[line_mem_pkg::OFFSET_W +: INDEX_W];
                model_tag[w_index]     <= expected_tag(aw_i.addr);
                model_data[w_index]    <= w_i.data;
                model_written[w_index] <= 1'b1;
                exp_bid                <= aw_i.id;
            end
        end
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("error at %0t: %s did not come within %0d cycles", $time, what, WAIT_LIMIT);
    endtask

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_quiet : assert property (@(posedge clk) disable iff (!rst_n)
        quiet |-> !(arready_o || rvalid_o || awready_o || wready_o || bvalid_o))
        else report_mismatch("handshake output high before any request");

    a_aw_latency : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(awvalid_i) |-> !awready_o ##1 !awready_o ##1 awready_o)
        else report_mismatch("awready_o not exactly 2 cycles after awvalid_i");

    a_b_latency : assert property (@(posedge clk) disable iff (!rst_n)
        (wvalid_i && wready_o) |=> $rose(bvalid_o))
        else report_mismatch("bvalid_o not 1 cycle after the W transfer");

    a_ar_latency : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(arvalid_i) |-> !arready_o ##1 arready_o ##1 (rvalid_o && !arready_o))
        else report_mismatch("arready_o or rvalid_o off the fixed read timing");

    a_r_hold : assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid_o && !rready_i) |=> (rvalid_o && $stable(r_o)))
        else report_mismatch("R beat dropped or changed under back-pressure");

    a_b_hold : assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid_o && !bready_i) |=> (bvalid_o && $stable(bid_o)))
        else report_mismatch("B response dropped or changed under back-pressure");

    a_r_data : assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid_o && rready_i) |-> (r_o == exp_r))
        else report_mismatch("R beat differs from model");

    a_r_tag_form : assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid_o && rready_i) |-> (r_o.tag.valid && !r_o.tag.dirty && r_o.tag.pad == '0))
        else report_mismatch("tag entry flags or padding wrong");

    a_b_id : assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_o |-> (bid_o == exp_bid))
        else report_mismatch("bid_o differs from AW id");

    // ----------------------------------------
    // stimulus tasks, called on a falling edge
    // ----------------------------------------
    task automatic random_line(output line_mem_pkg::line_data_t d);
        for (int i = 0; i < line_mem_pkg::DATA_W / 32; i++) begin
            d[i*32 +: 32] = $random(seed);
        end
    endtask

    task automatic random_addr(input int index, output logic [63:0] a);
        a = {$random(seed), $random(seed)};
        a[line_mem_pkg::OFFSET_W +: INDEX_W] = index[INDEX_W-1:0];
    endtask

    task automatic write_line(input logic [line_mem_pkg::ID_W-1:0] id, input logic [63:0] addr,
                              input line_mem_pkg::line_data_t data, input int bstall);
        int n;
        aw_i.id   = id;
        aw_i.addr = addr;
        w_i.id    = id;
        w_i.data  = data;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        n = 0;
        while (!awready_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!awready_o)
            report_timeout("awready_o");
        @(negedge clk);   // AW and W taken on the edge just passed
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        n = 0;
        while (!bvalid_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid_o)
            report_timeout("bvalid_o");
        repeat (bstall) @(negedge clk);
        bready_i = 1'b1;
        @(negedge clk);
        bready_i = 1'b0;
    endtask

    task automatic read_line(input logic [line_mem_pkg::ID_W-1:0] id, input logic [63:0] addr,
                             input int rstall);
        int n;
        ar_i.id   = id;
        ar_i.addr = addr;   // held after the transfer too
        arvalid_i = 1'b1;
        n = 0;
        while (!arready_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!arready_o)
            report_timeout("arready_o");
        @(negedge clk);
        arvalid_i = 1'b0;
        n = 0;
        while (!rvalid_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!rvalid_o)
            report_timeout("rvalid_o");
        repeat (rstall) @(negedge clk);
        rready_i = 1'b1;
        @(negedge clk);
        rready_i = 1'b0;
    endtask

    task automatic pick_written_index(output int index);
        int written[$];
        for (int i = 0; i < LINES; i++) begin
            if (model_written[i])
                written.push_back(i);
        end
        if (written.size() == 0) begin
            index = 0;
            errors++;
            $display("error at %0t: no written line left to read", $time);
        end else begin
            index = written[{$random(seed)} % written.size()];
        end
    endtask

    task automatic end_test(input string name);
        repeat (3) @(negedge clk);   // let the last checks fire
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED", tests_run, name);
        end
        errors_at_start = errors;
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        logic [63:0]              addr_a, addr_b, addr_w, addr_r;
        line_mem_pkg::line_data_t data_a, data_b, data_w;
        int                       idx_r;
        seed            = 59053;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        quiet           = 1'b1;
        rst_n           = 1'b0;
        ar_i            = '0;
        arvalid_i       = 1'b0;
        rready_i        = 1'b0;
        aw_i            = '0;
        awvalid_i       = 1'b0;
        w_i             = '0;
        wvalid_i        = 1'b0;
        bready_i        = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        repeat (6) @(negedge clk);
        quiet = 1'b0;
        end_test("idle outputs after reset");

        random_addr({$random(seed)} % LINES, addr_a);
        random_line(data_a);
        write_line(16'($random(seed)), addr_a, data_a, 0);
        read_line(16'($random(seed)), addr_a, 0);
        end_test("write then read back");

        for (int k = 0; k < 4; k++) begin
            random_addr(k, addr_a);
            random_line(data_a);
            write_line(16'($random(seed)), addr_a, data_a, 0);
            read_line(16'($random(seed)), addr_a, 0);
        end
        end_test("handshake timing");

        for (int k = 0; k < 8; k++) begin
            random_addr({$random(seed)} % LINES, addr_a);
            random_line(data_a);
            write_line(16'($random(seed)), addr_a, data_a, {$random(seed)} % 8);
            read_line(16'($random(seed)), addr_a, {$random(seed)} % 8);
        end
        end_test("R and B back-pressure");

        // same index, other upper bits
        random_addr(9, addr_a);
        addr_b = {~addr_a[63:32], addr_a[31:0]};
        random_line(data_a);
        random_line(data_b);
        write_line(16'($random(seed)), addr_a, data_a, 1);
        write_line(16'($random(seed)), addr_b, data_b, 0);
        read_line(16'($random(seed)), addr_a, 2);
        read_line(16'($random(seed)), addr_b, 0);
        end_test("same index replaced");

        fork
            begin
                for (int k = 0; k < 32; k++) begin
                    random_addr(k < LINES ? k : {$random(seed)} % LINES, addr_w);
                    random_line(data_w);
                    write_line(16'($random(seed)), addr_w, data_w, {$random(seed)} % 4);
                end
            end
            begin
                for (int k = 0; k < 32; k++) begin
                    pick_written_index(idx_r);
                    random_addr(idx_r, addr_r);
                    read_line(16'($random(seed)), addr_r, {$random(seed)} % 4);
                end
            end
        join
        end_test("concurrent random mix");

        repeat (4) @(negedge clk);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
hw/line_mem_pkg.sv
hw/line_store.sv
hw/line_write_ctrl.sv
hw/line_read_ctrl.sv
hw/line_mem.sv
tests/line_mem_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := line_mem_tb
FILELIST   := sim.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
